// ==== rtl/adc_pkg.sv ====
package adc_pkg;

	// ============================================================
	// Converter commands
	// ============================================================
	// Bit 0 is the pointer value, bit 2 marks a read
	typedef enum logic [2:0] {
		SET_CONV_RP   = 3'd0,   // Pointer -> conversion reg
		SET_CFG_RP    = 3'd1,   // Pointer -> config reg
		SET_CFG_DATA  = 3'd3,   // Pointer 1 plus two data bytes
		GET_CONV_DATA = 3'd4,   // Two-byte read
		GET_CFG_DATA  = 3'd5    // Two-byte read
	} adc_cmd_t;

	typedef logic [15:0] i2c_word_t;     // MSB byte first on the bus
	typedef logic [11:0] adc_sample_t;   // Left-justified in the word

	// ============================================================
	// I2C timing
	// ============================================================
	localparam int I2C_DIV   = 40;   // Clocks per bit and a multiple of 4
	localparam int I2C_DIV_W = $clog2(I2C_DIV);

	typedef logic [I2C_DIV_W-1:0] i2c_div_t;
	typedef logic [5:0]           i2c_bit_t;

	localparam i2c_div_t DIV_LAST = i2c_div_t'(I2C_DIV - 1);
	localparam i2c_div_t DIV_Q1   = i2c_div_t'(I2C_DIV / 4);      // SCL rises
	localparam i2c_div_t DIV_HALF = i2c_div_t'(I2C_DIV / 2);      // Sample point
	localparam i2c_div_t DIV_Q3   = i2c_div_t'(3 * I2C_DIV / 4);  // SCL falls

	// Bit periods per transaction, start and stop included
	localparam i2c_bit_t BITS_PTR_WR  = 6'd20;
	localparam i2c_bit_t BITS_CFG_WR  = 6'd38;
	localparam i2c_bit_t BITS_RD      = 6'd29;
	localparam i2c_bit_t ACK_ADDR_BIT = 6'd9;   // Ack slot after address

	localparam logic [6:0] I2C_ADDR = 7'h48;

endpackage

// ==== rtl/i2c_cmd_if.sv ====
`timescale 1ns/1ns

interface i2c_cmd_if
	import adc_pkg::*;
();

	adc_cmd_t  cmd;
	i2c_word_t wdata;
	i2c_word_t rdata;   // Valid with done
	logic      start;   // One cycle, engine idle only
	logic      done;    // End cycle of a transaction
	logic      error;   // Held until next start

	modport ctrl (
		output cmd,
		output wdata,
		output start,
		input  rdata,
		input  done,
		input  error
	);

	modport engine (
		input  cmd,
		input  wdata,
		input  start,
		output rdata,
		output done,
		output error
	);

endinterface

// ==== rtl/i2c_master.sv ====
`timescale 1ns/1ns

module i2c_master
	import adc_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	i2c_cmd_if.engine bus,
	output logic      o_scl,
	inout  wire       io_sda
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		ACK,
		DATA,
		STOP,
		DONE
	} state_t;

	state_t      state;
	i2c_div_t    clk_cnt;
	i2c_bit_t    bit_cnt;
	i2c_bit_t    bit_size;
	logic [2:0]  byte_bit;
	logic        rw;
	logic [31:0] tx_sr;
	logic        sda_q;
	logic        sda_in;
	logic        start_ok;
	logic        cmd_rd;
	logic        active;
	logic        bit_end;
	logic        sample_pt;
	logic        more_bytes;
	logic        slave_ack;

	assign io_sda = sda_q ? 1'bz : 1'b0;   // Open drain
	assign sda_in = io_sda;

	assign start_ok   = bus.start && (state == IDLE);
	assign cmd_rd     = (bus.cmd == GET_CONV_DATA) || (bus.cmd == GET_CFG_DATA);
	assign active     = (state != IDLE) && (state != DONE);
	assign bit_end    = (clk_cnt == DIV_LAST);
	assign sample_pt  = (clk_cnt == DIV_HALF);
	assign more_bytes = (bit_cnt + 6'd8 < bit_size);    // Another byte fits before stop
	assign slave_ack  = !rw || (bit_cnt == ACK_ADDR_BIT);
	assign bus.done   = (state == DONE);

	// ============================================================
	// Command latch
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_size <= '0;
			rw       <= 1'b0;
		end else if (start_ok) begin
			rw <= cmd_rd;
			case (bus.cmd)
				SET_CONV_RP, SET_CFG_RP:     bit_size <= BITS_PTR_WR;
				SET_CFG_DATA:                bit_size <= BITS_CFG_WR;
				GET_CONV_DATA, GET_CFG_DATA: bit_size <= BITS_RD;
				default:                     bit_size <= '0;   // Address only, then stop
			endcase
		end
	end

	// Address, pointer and data bytes as one frame
	always_ff @(posedge clk) begin
		if (start_ok)
			tx_sr <= {I2C_ADDR, cmd_rd, 7'd0, bus.cmd[0], bus.wdata};
		else if (bit_end && (state == ADDR || state == DATA))
			tx_sr <= {tx_sr[30:0], 1'b1};
	end

	// ============================================================
	// Bit timing
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			byte_bit <= '0;
		end else if (!active) begin
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			byte_bit <= '0;
		end else if (bit_end) begin
			clk_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			if (state == ADDR || state == DATA)
				byte_bit <= byte_bit + 1'b1;   // Wraps at byte end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_scl <= 1'b1;
		end else begin
			case (state)
				START:           o_scl <= (clk_cnt < DIV_HALF);
				ADDR, ACK, DATA: o_scl <= (clk_cnt >= DIV_Q1) && (clk_cnt < DIV_Q3);
				STOP:            o_scl <= (clk_cnt >= DIV_HALF);
				default:         o_scl <= 1'b1;
			endcase
		end
	end

	// ============================================================
	// SDA drive and sampling
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sda_q <= 1'b1;
		end else begin
			case (state)
				START: sda_q <= (clk_cnt < DIV_Q1);   // Falls while SCL high
				ADDR:  sda_q <= tx_sr[31];
				DATA:  sda_q <= rw | tx_sr[31];       // Released on reads
				// Master ack after the first read byte, nack after the last
				ACK:   sda_q <= !(rw && !slave_ack && more_bytes);
				STOP:  sda_q <= (clk_cnt >= DIV_Q3);  // Rises while SCL high
				default: sda_q <= 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == DATA && rw && sample_pt)
			bus.rdata <= {bus.rdata[14:0], sda_in};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bus.error <= 1'b0;
		else if (start_ok)
			bus.error <= 1'b0;
		else if (state == ACK && sample_pt && slave_ack && sda_in)
			bus.error <= 1'b1;   // Slave nack
	end

	// ============================================================
	// Transaction FSM
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start_ok)
						state <= START;
				end
				START: begin
					if (bit_end)
						state <= ADDR;
				end
				ADDR, DATA: begin
					if (bit_end && byte_bit == 3'd7)
						state <= ACK;
				end
				ACK: begin
					if (bit_end) begin
						if (bus.error)
							state <= DONE;   // No stop after a nack
						else if (more_bytes)
							state <= DATA;
						else
							state <= STOP;
					end
				end
				STOP: begin
					if (bit_end)
						state <= DONE;
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/adc_sequencer.sv ====
`timescale 1ns/1ns

module adc_sequencer
	import adc_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_enable,
	input  i2c_word_t   i_cfg,
	i2c_cmd_if.ctrl     bus,
	output adc_sample_t o_sample,
	output logic        o_sample_valid,
	output logic        o_error,
	output logic        o_busy
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CFG,    // Config write
		S_PTR,    // Pointer to conversion reg
		S_READ    // Back-to-back conversion reads
	} seq_state_t;

	seq_state_t state;
	logic       enable_q;
	logic       enable_rise;
	logic       clean_done;
	logic       fail_done;

	assign enable_rise = i_enable && !enable_q;
	assign clean_done  = bus.done && !bus.error;
	assign fail_done   = bus.done && bus.error;
	assign o_busy      = (state != S_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			enable_q <= 1'b0;
		else
			enable_q <= i_enable;
	end

	// ============================================================
	// Sequence FSM
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			bus.start <= 1'b0;
			bus.cmd   <= SET_CONV_RP;
			o_error   <= 1'b0;
		end else begin
			bus.start <= 1'b0;   // Strobe
			case (state)
				S_IDLE: begin
					if (enable_rise) begin
						state     <= S_CFG;
						bus.start <= 1'b1;
						bus.cmd   <= SET_CFG_DATA;
						o_error   <= 1'b0;
					end
				end
				S_CFG: begin
					if (clean_done) begin
						state     <= S_PTR;
						bus.start <= 1'b1;
						bus.cmd   <= SET_CONV_RP;
					end
				end
				S_PTR, S_READ: begin
					if (clean_done) begin
						if (i_enable) begin
							state     <= S_READ;
							bus.start <= 1'b1;
							bus.cmd   <= GET_CONV_DATA;
						end else begin
							state <= S_IDLE;   // Enable dropped
						end
					end
				end
				default: state <= S_IDLE;
			endcase
			if (fail_done) begin
				state   <= S_IDLE;
				o_error <= 1'b1;
			end
		end
	end

	// Config word held for the whole write
	always_ff @(posedge clk) begin
		if (state == S_IDLE && enable_rise)
			bus.wdata <= i_cfg;
	end

	// ============================================================
	// Sample output
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_sample_valid <= 1'b0;
		else
			o_sample_valid <= (state == S_READ) && clean_done;
	end

	always_ff @(posedge clk) begin
		if (state == S_READ && clean_done)
			o_sample <= bus.rdata[15:4];   // Result is left-justified
	end

endmodule

// ==== rtl/adc_top.sv ====
`timescale 1ns/1ns

module adc_top
	import adc_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_enable,
	input  i2c_word_t   i_cfg,
	output logic        o_scl,
	inout  wire         io_sda,
	output adc_sample_t o_sample,
	output logic        o_sample_valid,
	output logic        o_error,
	output logic        o_busy
);

	i2c_cmd_if cmd_bus ();

	adc_sequencer u_seq (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_enable       (i_enable),
		.i_cfg          (i_cfg),
		.bus            (cmd_bus.ctrl),
		.o_sample       (o_sample),
		.o_sample_valid (o_sample_valid),
		.o_error        (o_error),
		.o_busy         (o_busy)
	);

	// SDA pull-up lives outside the design
	i2c_master u_i2c (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (cmd_bus.engine),
		.o_scl  (o_scl),
		.io_sda (io_sda)
	);

endmodule

// ==== bench/tla2024_model.sv ====
`timescale 1ns/1ns

module tla2024_model
	import adc_pkg::*;
(
	input  logic      i_scl,
	inout  wire       io_sda,
	input  logic      i_nack,
	input  i2c_word_t i_conv,
	output i2c_word_t o_cfg,
	output int        o_read_count
);

	logic       sda_oe;
	logic       active;
	logic       rd;
	logic       master_ack;
	logic       ptr;
	logic [7:0] sr;
	logic [7:0] cfg_hi;
	i2c_word_t  tx;
	int         bitn;    // -1 until the first SCL fall after start
	int         byten;   // Bytes finished in this transfer

	assign io_sda = sda_oe ? 1'b0 : 1'bz;

	initial begin
		sda_oe       = 1'b0;
		active       = 1'b0;
		rd           = 1'b0;
		master_ack   = 1'b0;
		ptr          = 1'b0;
		sr           = '0;
		cfg_hi       = '0;
		tx           = '0;
		o_cfg        = 16'h8583;   // Power-on config
		o_read_count = 0;
		bitn         = -1;
		byten        = 0;
	end

	// ============================================================
	// Start and stop conditions
	// ============================================================
	always @(negedge io_sda) begin
		if (i_scl === 1'b1) begin
			active = 1'b1;
			bitn   = -1;
			byten  = 0;
			sda_oe = 1'b0;
		end
	end

	always @(posedge io_sda) begin
		if (i_scl === 1'b1) begin
			active = 1'b0;
			sda_oe = 1'b0;
		end
	end

	// ============================================================
	// Bit level
	// ============================================================
	always @(posedge i_scl) begin
		if (active) begin
			if (bitn >= 0 && bitn < 8)
				sr = {sr[6:0], io_sda};
			else if (bitn == 8)
				master_ack = (io_sda === 1'b0);   // Only used on reads
		end
	end

	always @(negedge i_scl) begin
		if (active) begin
			if (bitn < 0) begin
				bitn = 0;
			end else if (bitn < 7) begin
				bitn = bitn + 1;
				if (rd && byten > 0) begin
					sda_oe = !tx[15];
					tx     = {tx[14:0], 1'b0};
				end
			end else if (bitn == 7) begin
				bitn = 8;
				if (byten == 0) begin
					rd = sr[0];
					if (sr[7:1] == I2C_ADDR && !i_nack)
						sda_oe = 1'b1;   // Address ack
					else
						active = 1'b0;   // Not for us, stay off the bus
				end else if (!rd) begin
					if (byten == 1)
						ptr = sr[0];
					else if (byten == 2)
						cfg_hi = sr;
					else if (byten == 3)
						o_cfg = {cfg_hi, sr};
					sda_oe = 1'b1;
				end else begin
					sda_oe = 1'b0;   // Master acks read bytes
				end
			end else begin
				bitn  = 0;
				byten = byten + 1;
				if (!rd) begin
					sda_oe = 1'b0;
				end else if (byten == 1 || master_ack) begin
					if (byten == 1)
						tx = ptr ? o_cfg : i_conv;
					sda_oe = !tx[15];
					tx     = {tx[14:0], 1'b0};
				end else begin
					sda_oe       = 1'b0;   // Nack ends the read
					o_read_count = o_read_count + 1;
				end
			end
		end
	end

endmodule

// ==== bench/tb_adc_top.sv ====
`timescale 1ns/1ns

module tb_adc_top
	import adc_pkg::*;
();

	localparam int    N_ROWS      = 4;
	localparam int    N_SAMP      = 4;
	localparam int    TXN_PER_ROW = N_SAMP + 3;
	localparam longint TIME_LIMIT = 2 * N_ROWS * TXN_PER_ROW * 40 * I2C_DIV * 100;

	logic        clk;
	logic        rst_n;
	logic        i_enable;
	i2c_word_t   i_cfg;
	logic        scl;
	wire         sda;
	adc_sample_t o_sample;
	logic        o_sample_valid;
	logic        o_error;
	logic        o_busy;
	logic        model_nack;
	i2c_word_t   model_conv;
	i2c_word_t   model_cfg;
	int          read_count;
	int          seed;
	logic        start_seen = 1'b0;
	logic        bus_stopped = 1'b1;

	string     name_tab [N_ROWS];
	i2c_word_t cfg_tab  [N_ROWS];
	i2c_word_t conv_tab [N_ROWS][N_SAMP];
	logic      rand_tab [N_ROWS];
	logic      nack_tab [N_ROWS];

	pullup (sda);

	adc_top u_adc_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_enable       (i_enable),
		.i_cfg          (i_cfg),
		.o_scl          (scl),
		.io_sda         (sda),
		.o_sample       (o_sample),
		.o_sample_valid (o_sample_valid),
		.o_error        (o_error),
		.o_busy         (o_busy)
	);

	tla2024_model u_model (
		.i_scl        (scl),
		.io_sda       (sda),
		.i_nack       (model_nack),
		.i_conv       (model_conv),
		.o_cfg        (model_cfg),
		.o_read_count (read_count)
	);

	always #50 clk = !clk;

	// ============================================================
	// Reporting and compare tasks
	// ============================================================
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input adc_sample_t exp, input adc_sample_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			fail_run("Sample mismatch");
		end
	endtask

	task automatic check_word(input string name, input i2c_word_t exp, input i2c_word_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			fail_run("Register word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			fail_run("Flag mismatch");
		end
	endtask

	task automatic check_idle(input string name);
		check_flag({name, " scl"}, 1'b1, scl);
		check_flag({name, " sda"}, 1'b1, sda);
		check_flag({name, " valid"}, 1'b0, o_sample_valid);
		check_flag({name, " error"}, 1'b0, o_error);
		check_flag({name, " busy"}, 1'b0, o_busy);
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================
	task automatic load_table();
		name_tab[0] = "fixed_codes";
		cfg_tab[0]  = 16'h8483;
		conv_tab[0] = '{16'h7FF0, 16'h8000, 16'hFFF0, 16'h0010};
		rand_tab[0] = 1'b0;
		nack_tab[0] = 1'b0;
		name_tab[1] = "random_codes";
		cfg_tab[1]  = 16'hC2E3;
		rand_tab[1] = 1'b1;
		nack_tab[1] = 1'b0;
		name_tab[2] = "addr_nack";
		cfg_tab[2]  = 16'h8583;
		conv_tab[2] = '{16'h1230, 16'h4560, 16'h7890, 16'hABC0};
		rand_tab[2] = 1'b0;
		nack_tab[2] = 1'b1;
		name_tab[3] = "after_nack";
		cfg_tab[3]  = 16'hF1A3;
		rand_tab[3] = 1'b1;
		nack_tab[3] = 1'b0;
		for (int r = 0; r < N_ROWS; r++)
			if (rand_tab[r])
				for (int k = 0; k < N_SAMP; k++)
					conv_tab[r][k] = i2c_word_t'($random(seed));
	endtask

	task automatic run_row(input int r);
		int extra;
		int rc;
		string name;
		name = name_tab[r];
		@(posedge clk);
		model_nack <= nack_tab[r];
		model_conv <= conv_tab[r][0];
		i_cfg      <= cfg_tab[r];
		i_enable   <= 1'b1;
		do @(negedge clk); while (!o_busy);
		check_flag({name, " error cleared"}, 1'b0, o_error);
		extra = 0;
		if (nack_tab[r]) begin
			do begin
				@(negedge clk);
				if (o_sample_valid)
					extra++;
			end while (o_busy);
			check_flag({name, " error"}, 1'b1, o_error);
			check_flag({name, " no sample"}, 1'b1, extra == 0);
			@(posedge clk);
			i_enable <= 1'b0;
		end else begin
			for (int k = 0; k < N_SAMP; k++) begin
				do @(negedge clk); while (!o_sample_valid);
				if (k == 0)
					check_word({name, " cfg"}, cfg_tab[r], model_cfg);
				check_sample(name, conv_tab[r][k][15:4], o_sample);
				if (k < N_SAMP - 1) begin
					@(posedge clk);
					model_conv <= conv_tab[r][k + 1];
				end
			end
			@(posedge clk);
			i_enable <= 1'b0;
			do begin
				@(negedge clk);
				if (o_sample_valid) begin
					extra++;   // Read already in flight
					check_sample({name, " late"}, conv_tab[r][N_SAMP - 1][15:4], o_sample);
				end
			end while (o_busy);
			check_flag({name, " at most one late sample"}, 1'b1, extra <= 1);
			check_flag({name, " error"}, 1'b0, o_error);
			rc = read_count;
			repeat (40 * I2C_DIV) @(negedge clk);   // Longer than a whole read
			check_flag({name, " reads stopped"}, 1'b1, read_count == rc);
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		i_enable   = 1'b0;
		i_cfg      = '0;
		model_nack = 1'b0;
		model_conv = '0;
		seed       = 63;
		load_table();
		@(negedge clk);
		check_idle("in_reset");
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle("after_reset");
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		$display(">>> PASS");
		$finish;
	end

	initial begin
		#(TIME_LIMIT);
		fail_run("Timeout: the run did not finish within the watchdog limit");
	end

	// SDA may only move with SCL high for start and stop
	always @(sda) begin
		if (rst_n === 1'b1 && scl === 1'b1) begin
			if (sda === 1'b0) begin
				start_seen  = 1'b1;
				bus_stopped = 1'b0;
			end else if (start_seen) begin
				fail_run("SDA rose while SCL was high right after a start condition");
			end else begin
				bus_stopped = 1'b1;
			end
		end
	end

	always @(negedge scl) begin
		if (rst_n === 1'b1 && bus_stopped)
			fail_run("SDA rose while SCL was high in the middle of a transfer");
		start_seen = 1'b0;
	end

endmodule

// ==== sim.f ====
rtl/adc_pkg.sv
rtl/i2c_cmd_if.sv
rtl/i2c_master.sv
rtl/adc_sequencer.sv
rtl/adc_top.sv
bench/tla2024_model.sv
bench/tb_adc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ADC front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_adc_top

verilator --binary --timing -Wno-fatal --top-module tb_adc_top \
	-f sim.f -Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q ">>> FAIL" "$LOG"; then
	echo "Test failed, see $LOG"
	exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
	echo "No result found in $LOG"
	exit 1
fi
echo "Test passed"
exit 0
